//--- Makefile
# Verilator build, run and lint of the island memory system
VERILATOR  ?= verilator
TOP        ?= island_tb
RTL_TOP    ?= island_top
FLIST      ?= island.f
BUILD_DIR  ?= build
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

RTL_SRCS := $(filter source/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/island_tb.sv
// Default top parameters assumed; bank words are only checked once a full-word write has set them
`timescale 1ns/1ps

module island_tb;
  import island_pkg::*;

  localparam logic [31:0] BaseAddr     = 32'h0000_0000;
  localparam logic [31:0] MemOffset    = 32'h0000_0000;
  localparam int unsigned BankNumBytes = 4096;
  localparam logic [31:0] PeriphOffset = 32'h0020_0000;

  localparam logic [31:0] BankEnd       = BaseAddr + MemOffset + 2 * BankNumBytes;
  localparam logic [31:0] CtrlBase      = BaseAddr + PeriphOffset + SocCtrlAddrOffset;
  localparam logic [31:0] RomBase       = BaseAddr + PeriphOffset + BootRomAddrOffset;
  localparam logic [31:0] PrependBase   = BaseAddr + PeriphOffset + GlobalPrependAddrOffset;
  localparam logic [31:0] BootAddrReset = RomBase + BootAddrOffset;

  localparam int NumPool       = 16;
  localparam int NumRand       = 40;
  localparam int NumHammer     = 32;
  localparam int TotalOps      = 2 * NumPool + 2 * NumRand + 2 * NumHammer + 40;
  localparam int TimeoutCycles = TotalOps * 40 + 200;

  typedef struct packed {
    bus_rsp_t rsp;
    logic     chk_data;
  } expect_t;

  logic                     clk;
  logic                     rst_n;
  bootmode_e                bootmode;
  logic     [NumHosts-1:0]  host_req;
  bus_req_t [NumHosts-1:0]  host_req_data;
  logic     [NumHosts-1:0]  host_gnt;
  logic     [NumHosts-1:0]  host_rvalid;
  bus_rsp_t [NumHosts-1:0]  host_rsp;
  logic                     fetch_enable;
  logic     [31:0]          boot_addr;

  int          seed;
  int          errors = 0;
  int          rsp_count = 0;
  logic        hammer_on;
  logic [31:0] model_mem [logic [31:0]];
  expect_t     exp_q [NumHosts][$];
  logic [31:0] pool [NumPool];
  logic [31:0] rnd_ctl [NumHosts][NumRand];
  logic [31:0] rnd_dat [NumHosts][NumRand];

  island_top #(
    .BaseAddr     (BaseAddr),
    .MemOffset    (MemOffset),
    .BankNumBytes (BankNumBytes),
    .PeriphOffset (PeriphOffset)
  ) dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .bootmode_i      (bootmode),
    .host_req_i      (host_req),
    .host_req_data_i (host_req_data),
    .host_gnt_o      (host_gnt),
    .host_rvalid_o   (host_rvalid),
    .host_rsp_o      (host_rsp),
    .fetch_enable_o  (fetch_enable),
    .boot_addr_o     (boot_addr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic bus_rsp_t model_access(input logic [31:0] addr, input logic we,
                                            input logic [31:0] wdata, input logic [3:0] be,
                                            ref logic [31:0] mem [logic [31:0]],
                                            output logic data_known);
    bus_rsp_t    rsp;
    logic [31:0] key;
    logic [31:0] off;
    logic [31:0] mask;
    rsp        = '{rdata: 32'h0, err: 1'b0};
    key        = {addr[31:2], 2'b00};
    off        = addr - CtrlBase;
    mask       = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    data_known = 1'b1;
    if (addr < BankEnd) begin
      data_known = (mem.exists(key) != 0);
      if (data_known) rsp.rdata = mem[key];
      // A partial write to an unknown word leaves it unknown
      if (we && (data_known || be == 4'hf)) mem[key] = (rsp.rdata & ~mask) | (wdata & mask);
    end else if (off < PeriphSlotRange) begin
      if (off == 32'(RegBootAddr) || off == 32'(RegFetchEn) || off == 32'(RegBootMode)) begin
        rsp.rdata = mem[key];
        if (we && off == 32'(RegBootAddr)) begin
          mem[key] = (mem[key] & ~mask) | (wdata & mask);
        end else if (we && be[0]) begin
          mem[key] = wdata & ((off == 32'(RegFetchEn)) ? 32'h1 : 32'h3);
        end
      end else begin
        rsp.err = 1'b1;
      end
    end else if (addr - RomBase < PeriphSlotRange) begin
      rsp.rdata = (addr[11:2] < 10'(BootRomWords)) ? BootRomImage[addr[4:2]] : 32'h0;
    end else begin
      rsp = '{rdata: ErrorRdata, err: 1'b1};
    end
    return rsp;
  endfunction

  // ------------------------------
  // Host stimulus
  // ------------------------------
  task automatic access(input int h, input logic we, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be);
    int      waits;
    logic    known;
    expect_t want;
    host_req_data[h] = '{we: we, be: be, addr: addr, wdata: wdata};
    host_req[h]      = 1'b1;
    waits            = 0;
    @(negedge clk);
    while (!host_gnt[h] && waits < 8) begin
      waits++;
      @(negedge clk);
    end
    if (host_gnt[h]) begin
      want.rsp      = model_access(addr, we, wdata, be, model_mem, known);
      want.chk_data = known;
      exp_q[h].push_back(want);
    end else begin
      errors++;
      $display("host %0d was not granted within 8 cycles at address %h", h, addr);
    end
    @(posedge clk);
    #2;
    host_req[h] = 1'b0;
  endtask

  task automatic reset_with(input bootmode_e mode);
    bootmode = mode;
    rst_n    = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (fetch_enable !== 1'b0) begin
      errors++;
      $display("[ERROR] fetch_enable_o: got %h, expected %h before capture", fetch_enable, 1'b0);
    end
    @(negedge clk);
    if (fetch_enable !== (mode == Jtag)) begin
      errors++;
      $display("[ERROR] fetch_enable_o: got %h, expected %h", fetch_enable, mode == Jtag);
    end
    if (boot_addr !== BootAddrReset) begin
      errors++;
      $display("[ERROR] boot_addr_o: got %h, expected %h", boot_addr, BootAddrReset);
    end
    model_mem[CtrlBase]         = BootAddrReset;
    model_mem[CtrlBase + 32'h4] = {31'h0, mode == Jtag};
    model_mem[CtrlBase + 32'h8] = {30'h0, mode};
    @(posedge clk);
    #2;
  endtask

  // Pins follow the registers one edge after a write
  task automatic check_pins();
    @(negedge clk);
    if (boot_addr !== model_mem[CtrlBase]) begin
      errors++;
      $display("[ERROR] boot_addr_o: got %h, expected %h", boot_addr, model_mem[CtrlBase]);
    end
    if (fetch_enable !== model_mem[CtrlBase + 32'h4][0]) begin
      errors++;
      $display("[ERROR] fetch_enable_o: got %h, expected %h", fetch_enable,
               model_mem[CtrlBase + 32'h4][0]);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic fill_pool(input int h);
    for (int i = h * NumPool / 2; i < (h + 1) * NumPool / 2; i++) begin
      access(h, 1'b1, pool[i], rnd_dat[h][i % NumRand] ^ pool[i], 4'hf);
    end
  endtask

  task automatic random_ops(input int h);
    logic [31:0] ctl;
    for (int i = 0; i < NumRand; i++) begin
      ctl = rnd_ctl[h][i];
      access(h, ctl[4], pool[ctl[3:0]], rnd_dat[h][i], ctl[8:5]);
    end
  endtask

  // Each host owns its own words in bank 0
  task automatic hammer(input int h);
    logic [31:0] addr;
    for (int i = 0; i < NumHammer; i++) begin
      addr = 32'h400 + 32'(8 * (i / 2) + 4 * h);
      access(h, (i % 2) == 0, addr, {16'hC0DE, 8'(h), 8'(i)}, 4'hf);
    end
  endtask

  // ------------------------------
  // Response compare
  // ------------------------------
  initial begin
    expect_t             want;
    logic [1:0]          last_gnt;
    logic [NumHosts-1:0] gnt_prev;
    last_gnt = 2'b00;
    gnt_prev = '0;
    forever begin
      @(negedge clk);
      // Every grant is answered exactly one cycle later
      if (host_rvalid !== gnt_prev) begin
        errors++;
        $display("[ERROR] host_rvalid_o: got %h, expected %h", host_rvalid, gnt_prev);
      end
      gnt_prev = host_gnt & host_req;
      for (int h = 0; h < NumHosts; h++) begin
        if (host_rvalid[h]) begin
          if (exp_q[h].size() == 0) begin
            errors++;
            $display("host %0d received a response with no request outstanding", h);
          end else begin
            want = exp_q[h].pop_front();
            rsp_count++;
            if (want.chk_data && host_rsp[h].rdata !== want.rsp.rdata) begin
              errors++;
              $display("[ERROR] host_rsp_o[%0d].rdata: got %h, expected %h", h,
                       host_rsp[h].rdata, want.rsp.rdata);
            end
            if (host_rsp[h].err !== want.rsp.err) begin
              errors++;
              $display("[ERROR] host_rsp_o[%0d].err: got %h, expected %h", h,
                       host_rsp[h].err, want.rsp.err);
            end
          end
        end
      end
      if (!hammer_on) last_gnt = 2'b00;
      if (hammer_on && host_req == 2'b11) begin
        if (host_gnt != 2'b01 && host_gnt != 2'b10) begin
          errors++;
          $display("[ERROR] host_gnt_o: got %h, expected one host only", host_gnt);
        end else if (host_gnt == last_gnt) begin
          errors++;
          $display("[ERROR] host_gnt_o: got %h, expected %h", host_gnt, ~last_gnt);
        end
        last_gnt = host_gnt;
      end
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("timeout after %0d cycles, the run did not finish", TimeoutCycles);
    $display("tests failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    seed          = 32'h4c21883a;
    rst_n         = 1'b0;
    bootmode      = Local;
    host_req      = '0;
    host_req_data = '0;
    hammer_on     = 1'b0;
    for (int i = 0; i < NumPool; i++) begin
      pool[i] = ((i % 2) == 1 ? 32'(BankNumBytes) : 32'h0) + (32'($random(seed)) & 32'hffc);
    end
    for (int h = 0; h < NumHosts; h++) begin
      for (int i = 0; i < NumRand; i++) begin
        rnd_ctl[h][i] = 32'($random(seed));
        rnd_dat[h][i] = 32'($random(seed));
      end
    end

    reset_with(Jtag);
    reset_with(Local);

    // Banks, full-word fill then mixed partial traffic
    fork
      fill_pool(0);
      fill_pool(1);
    join
    fork
      random_ops(0);
      random_ops(1);
    join
    for (int i = 0; i < NumPool; i++) access(1, 1'b0, pool[i], 32'h0, 4'hf);

    hammer_on = 1'b1;
    fork
      hammer(0);
      hammer(1);
    join
    hammer_on = 1'b0;

    // Boot ROM, prepend slot and unmapped peripheral space
    for (int i = 0; i < 10; i++) access(1, 1'b0, RomBase + 32'(4 * i), 32'h0, 4'hf);
    access(0, 1'b0, PrependBase + 32'h10, 32'h0, 4'hf);
    access(0, 1'b1, PrependBase, 32'h5555_aaaa, 4'hf);
    access(1, 1'b0, PrependBase + 32'h1000, 32'h0, 4'hf);
    access(1, 1'b1, PrependBase + 32'h1004, 32'h1234_0000, 4'h3);
    access(0, 1'b0, 32'h0001_0000, 32'h0, 4'hf);

    // SoC control registers
    access(0, 1'b0, CtrlBase, 32'h0, 4'hf);
    access(0, 1'b1, CtrlBase, 32'h1234_5678, 4'hf);
    check_pins();
    access(1, 1'b1, CtrlBase, 32'haaaa_bbbb, 4'b0100);
    check_pins();
    access(0, 1'b1, CtrlBase + 32'h4, 32'h0000_0001, 4'h1);
    check_pins();
    access(1, 1'b1, CtrlBase + 32'h8, 32'h0000_0002, 4'h1);
    check_pins();
    access(0, 1'b0, CtrlBase, 32'h0, 4'hf);
    access(0, 1'b0, CtrlBase + 32'h4, 32'h0, 4'hf);
    access(0, 1'b0, CtrlBase + 32'h8, 32'h0, 4'hf);
    access(1, 1'b0, CtrlBase + 32'hc, 32'h0, 4'hf);
    access(1, 1'b0, CtrlBase + 32'h1, 32'h0, 4'hf);
    access(0, 1'b1, CtrlBase + 32'h10, 32'hffff_ffff, 4'hf);
    check_pins();

    repeat (3) @(posedge clk);
    for (int h = 0; h < NumHosts; h++) begin
      if (exp_q[h].size() != 0) begin
        errors++;
        $display("host %0d is missing %0d responses", h, exp_q[h].size());
      end
    end
    $display("responses checked: %0d, errors: %0d", rsp_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- island.f
source/island_pkg.sv
source/island_xbar.sv
source/island_sram_bank.sv
source/island_periph_demux.sv
source/island_soc_ctrl.sv
source/island_top.sv
bench/island_tb.sv

//--- source/island_periph_demux.sv
// Always grants; boot ROM ignores writes and unmatched slots answer with an error response
`timescale 1ns/1ps

module island_periph_demux #(
  parameter logic [31:0] BaseAddr     = 32'h0000_0000,
  parameter logic [31:0] PeriphOffset = 32'h0020_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  island_pkg::bus_req_t req_data_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output island_pkg::bus_rsp_t rsp_o,
  // SoC control port
  output logic                 ctrl_req_o,
  output island_pkg::bus_req_t ctrl_req_data_o,
  input  island_pkg::bus_rsp_t ctrl_rsp_i
);
  import island_pkg::*;

  localparam logic [31:0] PeriphBase  = BaseAddr + PeriphOffset;
  localparam logic [31:0] SocCtrlBase = PeriphBase + SocCtrlAddrOffset;
  localparam int unsigned RomIdxW     = $clog2(BootRomWords);

  typedef enum logic [1:0] {
    SelError,
    SelSocCtrl,
    SelBootRom
  } periph_sel_e;

  periph_sel_e sel;
  logic [31:0] slot_off;
  logic [9:0]  rom_idx;
  logic [31:0] rom_word;
  bus_rsp_t    rsp_d;
  bus_rsp_t    rsp_q;
  logic        rvalid_q;

  // ------------------------------
  // Slot decode
  // ------------------------------
  // Subtract then compare, so addresses below a slot wrap and miss it
  assign slot_off = req_data_i.addr - PeriphBase;

  always_comb begin
    if ((slot_off - SocCtrlAddrOffset) < PeriphSlotRange) begin
      sel = SelSocCtrl;
    end else if ((slot_off - BootRomAddrOffset) < PeriphSlotRange) begin
      sel = SelBootRom;
    end else begin
      sel = SelError;
    end
  end

  assign ctrl_req_o      = req_i && (sel == SelSocCtrl);
  assign ctrl_req_data_o = req_data_i;

  // Boot ROM, words past the image read as zero
  assign rom_idx  = req_data_i.addr[11:2];
  assign rom_word = (rom_idx < BootRomWords) ? BootRomImage[rom_idx[RomIdxW-1:0]] : '0;

  // ------------------------------
  // Response select and register
  // ------------------------------
  always_comb begin
    unique case (sel)
      SelSocCtrl: rsp_d = ctrl_rsp_i;
      SelBootRom: rsp_d = '{rdata: rom_word, err: 1'b0};
      // Prepend slot and unmapped space have no device behind them
      default:    rsp_d = '{rdata: ErrorRdata, err: 1'b1};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rsp_q <= rsp_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign gnt_o    = 1'b1;
  assign rvalid_o = rvalid_q;
  assign rsp_o    = rsp_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_req_o |-> (ctrl_req_data_o.addr >= SocCtrlBase) &&
                   (ctrl_req_data_o.addr < SocCtrlBase + PeriphSlotRange))
    else $error("periph demux: SoC control request outside its slot");

endmodule

//--- source/island_pkg.sv
// Bus types and peripheral map for the island; the boot ROM image is a fixed jump loop
package island_pkg;

  // ------------------------------
  // Crossbar sizes and target indices
  // ------------------------------
  localparam int unsigned NumHosts   = 2;
  localparam int unsigned NumTargets = 3;

  localparam int unsigned TgtBank0  = 0;
  localparam int unsigned TgtBank1  = 1;
  localparam int unsigned TgtPeriph = 2;

  // Request payload, one per granted cycle
  typedef struct packed {
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Response payload, valid with rvalid
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    Local     = 2'd0,
    Jtag      = 2'd1,
    Preloaded = 2'd2
  } bootmode_e;

  // ------------------------------
  // Peripheral region map
  // ------------------------------
  localparam logic [31:0] SocCtrlAddrOffset       = 32'h0000_0000;
  localparam logic [31:0] BootRomAddrOffset       = 32'h0000_1000;
  localparam logic [31:0] GlobalPrependAddrOffset = 32'h0000_2000;
  localparam logic [31:0] PeriphSlotRange         = 32'h0000_1000;

  localparam logic [31:0] ErrorRdata = 32'hBADCAB1E;

  // Boot ROM contents, word 0 first
  localparam int unsigned BootRomWords = 8;
  localparam logic [0:BootRomWords-1][31:0] BootRomImage = '{
    32'h0000_0297,  // auipc t0, 0
    32'h0802_8293,  // addi  t0, t0, 0x80
    32'h0002_8067,  // jr    t0
    32'h0000_0013,
    32'h0000_0013,
    32'h1050_0073,  // wfi
    32'hffdf_f06f,  // back to wfi
    32'h0000_0013
  };

  // ------------------------------
  // SoC control register offsets
  // ------------------------------
  localparam logic [11:0] RegBootAddr = 12'h000;
  localparam logic [11:0] RegFetchEn  = 12'h004;
  localparam logic [11:0] RegBootMode = 12'h008;

  // Reset boot address sits this far into the boot ROM
  localparam logic [31:0] BootAddrOffset = 32'h0000_0080;

endpackage

//--- source/island_soc_ctrl.sv
// Response is combinational; boot mode pins are sampled only in the first cycle after reset
`timescale 1ns/1ps

module island_soc_ctrl #(
  parameter logic [31:0] BaseAddr     = 32'h0000_0000,
  parameter logic [31:0] PeriphOffset = 32'h0020_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  island_pkg::bus_req_t  req_data_i,
  input  island_pkg::bootmode_e bootmode_i,
  output island_pkg::bus_rsp_t  rsp_o,
  output logic                  fetch_enable_o,
  output logic [31:0]           boot_addr_o
);
  import island_pkg::*;

  localparam logic [31:0] PeriphBase    = BaseAddr + PeriphOffset;
  localparam logic [31:0] SocCtrlBase   = PeriphBase + SocCtrlAddrOffset;
  localparam logic [31:0] BootAddrReset = PeriphBase + BootRomAddrOffset + BootAddrOffset;

  logic [11:0] reg_off;
  logic        wr_en;
  logic        first_cycle_q;
  logic [31:0] boot_addr_q;
  logic        fetch_en_q;
  bootmode_e   boot_mode_q;

  function automatic logic [31:0] apply_be(logic [31:0] old_val, logic [31:0] new_val,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reg_off = 12'(req_data_i.addr - SocCtrlBase);
  assign wr_en   = req_i && req_data_i.we;

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      boot_addr_q   <= BootAddrReset;
      fetch_en_q    <= 1'b0;
      boot_mode_q   <= Local;
    end else begin
      first_cycle_q <= 1'b0;
      if (wr_en && reg_off == RegBootAddr) begin
        boot_addr_q <= apply_be(boot_addr_q, req_data_i.wdata, req_data_i.be);
      end
      // Pin capture wins over a bus write in the first cycle
      if (first_cycle_q) begin
        boot_mode_q <= bootmode_i;
        fetch_en_q  <= (bootmode_i == Jtag);
      end else begin
        if (wr_en && reg_off == RegFetchEn && req_data_i.be[0]) begin
          fetch_en_q <= req_data_i.wdata[0];
        end
        if (wr_en && reg_off == RegBootMode && req_data_i.be[0]) begin
          boot_mode_q <= bootmode_e'(req_data_i.wdata[1:0]);
        end
      end
    end
  end

  // Read data, unmapped offsets flag an error
  always_comb begin
    rsp_o = '{rdata: '0, err: 1'b0};
    unique case (reg_off)
      RegBootAddr: rsp_o.rdata = boot_addr_q;
      RegFetchEn:  rsp_o.rdata = {31'b0, fetch_en_q};
      RegBootMode: rsp_o.rdata = {30'b0, boot_mode_q};
      default:     rsp_o.err   = 1'b1;
    endcase
  end

  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    first_cycle_q |=> (fetch_enable_o == ($past(bootmode_i) == Jtag)))
    else $error("soc ctrl: fetch enable does not follow captured boot mode");

endmodule

//--- source/island_sram_bank.sv
// NumWords must be a power of two; the address wraps modulo the bank size
`timescale 1ns/1ps

module island_sram_bank #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  island_pkg::bus_req_t req_data_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output island_pkg::bus_rsp_t rsp_o
);
  import island_pkg::*;

  localparam int unsigned IdxW = $clog2(NumWords);

  logic [31:0]     mem_q [NumWords];
  logic [IdxW-1:0] word_idx;
  logic [31:0]     rdata_q;
  logic            rvalid_q;

  assign word_idx = req_data_i.addr[IdxW+1:2];
  assign gnt_o    = 1'b1;

  // Read returns the word before any write in the same cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= mem_q[word_idx];
      if (req_data_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_data_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(req_data_i.addr))
    else $error("sram bank: unknown address on request");

endmodule

//--- source/island_top.sv
// Two hosts share two SRAM banks and the peripheral region; addresses outside the banks go to periphs
`timescale 1ns/1ps

module island_top #(
  parameter logic [31:0] BaseAddr     = 32'h0000_0000,
  parameter logic [31:0] MemOffset    = 32'h0000_0000,
  parameter int unsigned BankNumBytes = 4096,
  parameter logic [31:0] PeriphOffset = 32'h0020_0000
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  island_pkg::bootmode_e                           bootmode_i,
  input  logic                 [island_pkg::NumHosts-1:0] host_req_i,
  input  island_pkg::bus_req_t [island_pkg::NumHosts-1:0] host_req_data_i,
  output logic                 [island_pkg::NumHosts-1:0] host_gnt_o,
  output logic                 [island_pkg::NumHosts-1:0] host_rvalid_o,
  output island_pkg::bus_rsp_t [island_pkg::NumHosts-1:0] host_rsp_o,
  output logic                                            fetch_enable_o,
  output logic                 [31:0]                     boot_addr_o
);
  import island_pkg::*;

  logic     [NumTargets-1:0] tgt_req;
  bus_req_t [NumTargets-1:0] tgt_req_data;
  logic     [NumTargets-1:0] tgt_gnt;
  logic     [NumTargets-1:0] tgt_rvalid;
  bus_rsp_t [NumTargets-1:0] tgt_rsp;

  logic     ctrl_req;
  bus_req_t ctrl_req_data;
  bus_rsp_t ctrl_rsp;

  // ------------------------------
  // Interconnect
  // ------------------------------
  island_xbar #(
    .BaseAddr     (BaseAddr),
    .MemOffset    (MemOffset),
    .BankNumBytes (BankNumBytes)
  ) i_xbar (
    .clk_i,
    .rst_ni,
    .host_req_i,
    .host_req_data_i,
    .host_gnt_o,
    .host_rvalid_o,
    .host_rsp_o,
    .tgt_req_o      (tgt_req),
    .tgt_req_data_o (tgt_req_data),
    .tgt_gnt_i      (tgt_gnt),
    .tgt_rvalid_i   (tgt_rvalid),
    .tgt_rsp_i      (tgt_rsp)
  );

  // ------------------------------
  // Memory banks
  // ------------------------------
  for (genvar b = 0; b < 2; b++) begin : gen_bank
    island_sram_bank #(
      .NumWords (BankNumBytes / 4)
    ) i_bank (
      .clk_i,
      .rst_ni,
      .req_i      (tgt_req[TgtBank0 + b]),
      .req_data_i (tgt_req_data[TgtBank0 + b]),
      .gnt_o      (tgt_gnt[TgtBank0 + b]),
      .rvalid_o   (tgt_rvalid[TgtBank0 + b]),
      .rsp_o      (tgt_rsp[TgtBank0 + b])
    );
  end

  // ------------------------------
  // Peripherals
  // ------------------------------
  island_periph_demux #(
    .BaseAddr     (BaseAddr),
    .PeriphOffset (PeriphOffset)
  ) i_periph_demux (
    .clk_i,
    .rst_ni,
    .req_i           (tgt_req[TgtPeriph]),
    .req_data_i      (tgt_req_data[TgtPeriph]),
    .gnt_o           (tgt_gnt[TgtPeriph]),
    .rvalid_o        (tgt_rvalid[TgtPeriph]),
    .rsp_o           (tgt_rsp[TgtPeriph]),
    .ctrl_req_o      (ctrl_req),
    .ctrl_req_data_o (ctrl_req_data),
    .ctrl_rsp_i      (ctrl_rsp)
  );

  island_soc_ctrl #(
    .BaseAddr     (BaseAddr),
    .PeriphOffset (PeriphOffset)
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i          (ctrl_req),
    .req_data_i     (ctrl_req_data),
    .bootmode_i,
    .rsp_o          (ctrl_rsp),
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

//--- source/island_xbar.sv
// Two hosts only (one-bit round-robin pointer); targets must answer exactly one cycle after grant
`timescale 1ns/1ps

module island_xbar #(
  parameter logic [31:0] BaseAddr     = 32'h0000_0000,
  parameter logic [31:0] MemOffset    = 32'h0000_0000,
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Host side
  input  logic                 [island_pkg::NumHosts-1:0]   host_req_i,
  input  island_pkg::bus_req_t [island_pkg::NumHosts-1:0]   host_req_data_i,
  output logic                 [island_pkg::NumHosts-1:0]   host_gnt_o,
  output logic                 [island_pkg::NumHosts-1:0]   host_rvalid_o,
  output island_pkg::bus_rsp_t [island_pkg::NumHosts-1:0]   host_rsp_o,
  // Target side
  output logic                 [island_pkg::NumTargets-1:0] tgt_req_o,
  output island_pkg::bus_req_t [island_pkg::NumTargets-1:0] tgt_req_data_o,
  input  logic                 [island_pkg::NumTargets-1:0] tgt_gnt_i,
  input  logic                 [island_pkg::NumTargets-1:0] tgt_rvalid_i,
  input  island_pkg::bus_rsp_t [island_pkg::NumTargets-1:0] tgt_rsp_i
);
  import island_pkg::*;

  localparam logic [31:0] Bank0Start = BaseAddr + MemOffset;
  localparam logic [31:0] Bank1Start = Bank0Start + BankNumBytes;
  localparam logic [31:0] Bank1End   = Bank1Start + BankNumBytes;

  typedef logic [$clog2(NumTargets)-1:0] tgt_idx_t;

  tgt_idx_t [NumHosts-1:0]             host_tgt;
  logic     [NumTargets-1:0][NumHosts-1:0] tgt_host_req;
  logic     [NumTargets-1:0]             win_host;
  // Host granted last by each target
  logic     [NumTargets-1:0]             rr_last_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    for (int h = 0; h < NumHosts; h++) begin
      if (host_req_data_i[h].addr >= Bank0Start && host_req_data_i[h].addr < Bank1Start) begin
        host_tgt[h] = tgt_idx_t'(TgtBank0);
      end else if (host_req_data_i[h].addr >= Bank1Start &&
                   host_req_data_i[h].addr < Bank1End) begin
        host_tgt[h] = tgt_idx_t'(TgtBank1);
      end else begin
        // Everything else lands in the peripheral region
        host_tgt[h] = tgt_idx_t'(TgtPeriph);
      end
    end
  end

  // ------------------------------
  // Per-target arbitration
  // ------------------------------
  always_comb begin
    for (int t = 0; t < NumTargets; t++) begin
      for (int h = 0; h < NumHosts; h++) begin
        tgt_host_req[t][h] = host_req_i[h] && (host_tgt[h] == tgt_idx_t'(t));
      end
      // On conflict the host not served last wins
      if (&tgt_host_req[t]) begin
        win_host[t] = ~rr_last_q[t];
      end else begin
        win_host[t] = tgt_host_req[t][1];
      end
      tgt_req_o[t]      = |tgt_host_req[t];
      tgt_req_data_o[t] = host_req_data_i[win_host[t]];
    end
  end

  always_comb begin
    for (int h = 0; h < NumHosts; h++) begin
      host_gnt_o[h] = host_req_i[h] && tgt_gnt_i[host_tgt[h]] &&
                      (win_host[host_tgt[h]] == 1'(h));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_last_q <= '0;
    end else begin
      for (int t = 0; t < NumTargets; t++) begin
        if (tgt_req_o[t] && tgt_gnt_i[t]) begin
          rr_last_q[t] <= win_host[t];
        end
      end
    end
  end

  // ------------------------------
  // Response return
  // ------------------------------
  // rvalid follows the grant by one cycle, so the pointer still names the requester
  always_comb begin
    host_rvalid_o = '0;
    host_rsp_o    = '0;
    for (int t = 0; t < NumTargets; t++) begin
      if (tgt_rvalid_i[t]) begin
        host_rvalid_o[rr_last_q[t]] = 1'b1;
        host_rsp_o[rr_last_q[t]]    = tgt_rsp_i[t];
      end
    end
  end

  for (genvar g = 0; g < NumTargets; g++) begin : gen_tgt_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(host_gnt_o & tgt_host_req[g]))
      else $error("xbar: target %0d granted more than one host", g);
  end

  for (genvar g = 0; g < NumHosts; g++) begin : gen_host_check
    // Grant needs a request and brings the response back next cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      host_gnt_o[g] |-> host_req_i[g] ##1 host_rvalid_o[g])
      else $error("xbar: host %0d grant without request or response", g);
  end

endmodule
